// ==== hw/store_pkg.sv ====
package store_pkg;

	// ******************************
	// array geometry
	// ******************************

	localparam int data_w = 8;	// bits per stored word
	localparam int addr_w = 3;
	localparam int data_n = 8;	// 2**addr_w entries

	// ******************************
	// host operation codes
	// ******************************

	localparam int op_w = 2;

	localparam logic [op_w-1:0] op_read  = 2'd0;
	localparam logic [op_w-1:0] op_write = 2'd1;
	localparam logic [op_w-1:0] op_clear = 2'd2;
	// code 3 is reserved, acked with no array access

	// command port controller states
	localparam int st_w = 2;

	localparam logic [st_w-1:0] st_idle  = 2'd0;
	localparam logic [st_w-1:0] st_issue = 2'd1;
	localparam logic [st_w-1:0] st_hold  = 2'd2;	// response capture and ack

endpackage

// ==== hw/reg_array.sv ====
`timescale 1ns/1ps

module reg_array
	import store_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,

	input  logic [data_w-1:0] din,
	input  logic [addr_w-1:0] addr,
	input  logic              wr,
	input  logic              rd,
	input  logic              clr,

	output logic [data_w-1:0] dout,
	output logic              error
);

	// ******************************
	// storage
	// ******************************

	logic [data_w-1:0] data_q [data_n];	// payload, never reset
	logic [data_n-1:0] valid_q;

	// per entry decode and read terms
	logic [data_n-1:0] addr_hit;
	logic [data_n-1:0] wr_en;
	logic [data_n-1:0] rd_en;
	logic [data_n-1:0] rd_v;
	logic [data_w-1:0] data_rd [data_n];

	// ******************************
	// one-hot address decode
	// ******************************

	generate
		for (genvar i = 0; i < data_n; i++) begin : g_entry
			assign addr_hit[i] = (addr == addr_w'(i));
			assign wr_en[i]    = wr & addr_hit[i];
			assign rd_en[i]    = rd & addr_hit[i];

			// only a valid entry may drive the read bus
			assign rd_v[i]    = rd_en[i] & valid_q[i];
			assign data_rd[i] = {data_w{rd_v[i]}} & data_q[i];

			always_ff @(posedge clk) begin
				if (wr_en[i]) begin
					data_q[i] <= din;
				end
			end
		end
	endgenerate

	// ******************************
	// valid bits
	// ******************************

	// a write sets the addressed bit, clear drops them all
	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_q <= '0;
		end else if (clr) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_q | wr_en;
		end
	end

	// ******************************
	// read path
	// ******************************

	// at most one rd_v bit is set, so an OR acts as the mux
	always_comb begin
		dout = '0;
		for (int i = 0; i < data_n; i++) begin
			dout = dout | data_rd[i];
		end
	end

	// reading an entry that was never written, or was cleared
	assign error = rd & ~|rd_v;

endmodule

// ==== hw/cmd_port.sv ====
`timescale 1ns/1ps

module cmd_port
	import store_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,

	// host side, four-phase req/ack
	input  logic              req,
	input  logic [op_w-1:0]   op,
	input  logic [addr_w-1:0] addr,
	input  logic [data_w-1:0] wdata,
	output logic              ack,
	output logic [data_w-1:0] rdata,
	output logic              err,

	// array side
	output logic [data_w-1:0] arr_din,
	output logic [addr_w-1:0] arr_addr,
	output logic              arr_wr,
	output logic              arr_rd,
	output logic              arr_clr,
	input  logic [data_w-1:0] arr_dout,
	input  logic              arr_error
);

	// ******************************
	// state and command latch
	// ******************************

	logic [st_w-1:0]   state_q;
	logic [op_w-1:0]   cmd_op_q;
	logic [addr_w-1:0] cmd_addr_q;
	logic [data_w-1:0] cmd_wdata_q;

	logic take_cmd;

	// decoded strobes, loaded in issue
	logic dec_wr;
	logic dec_rd;
	logic dec_clr;

	assign take_cmd = (state_q == st_idle) & req;

	// host holds these stable while req is high
	always_ff @(posedge clk) begin
		if (take_cmd) begin
			cmd_op_q    <= op;
			cmd_addr_q  <= addr;
			cmd_wdata_q <= wdata;
		end
	end

	assign arr_din  = cmd_wdata_q;
	assign arr_addr = cmd_addr_q;

	// ******************************
	// op decode
	// ******************************

	always_comb begin
		dec_wr  = 1'b0;
		dec_rd  = 1'b0;
		dec_clr = 1'b0;
		case (cmd_op_q)
			op_read:  dec_rd  = 1'b1;
			op_write: dec_wr  = 1'b1;
			op_clear: dec_clr = 1'b1;
			default: begin
				// reserved, no strobe
				dec_wr  = 1'b0;
			end
		endcase
	end

	// ******************************
	// handshake FSM
	// ******************************

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= st_idle;
			ack     <= 1'b0;
			arr_wr  <= 1'b0;
			arr_rd  <= 1'b0;
			arr_clr <= 1'b0;
			rdata   <= '0;
			err     <= 1'b0;
		end else begin
			// strobes last one cycle
			arr_wr  <= 1'b0;
			arr_rd  <= 1'b0;
			arr_clr <= 1'b0;

			case (state_q)
				st_idle: begin
					if (req) begin
						state_q <= st_issue;	// command latched this edge
					end
				end

				st_issue: begin
					arr_wr  <= dec_wr;
					arr_rd  <= dec_rd;
					arr_clr <= dec_clr;
					state_q <= st_hold;
				end

				st_hold: begin
					if (!ack) begin
						// strobe cycle ends here, array answer is valid
						ack   <= 1'b1;
						rdata <= arr_rd ? arr_dout : '0;
						err   <= arr_rd & arr_error;
					end else if (!req) begin
						ack     <= 1'b0;	// rdata and err keep their value
						state_q <= st_idle;
					end
				end

				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== hw/scratch_store.sv ====
`timescale 1ns/1ps

module scratch_store
	import store_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,

	// host command port
	input  logic              req,
	input  logic [op_w-1:0]   op,
	input  logic [addr_w-1:0] addr,
	input  logic [data_w-1:0] wdata,

	output logic              ack,
	output logic [data_w-1:0] rdata,
	output logic              err
);

	// ******************************
	// controller to array
	// ******************************

	logic [data_w-1:0] arr_din;
	logic [addr_w-1:0] arr_addr;
	logic              arr_wr;
	logic              arr_rd;
	logic              arr_clr;

	// combinational answer of the array
	logic [data_w-1:0] arr_dout;
	logic              arr_error;

	cmd_port u_port (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.ack       (ack),
		.rdata     (rdata),
		.err       (err),
		.arr_din   (arr_din),
		.arr_addr  (arr_addr),
		.arr_wr    (arr_wr),
		.arr_rd    (arr_rd),
		.arr_clr   (arr_clr),
		.arr_dout  (arr_dout),
		.arr_error (arr_error)
	);

	reg_array u_array (
		.clk    (clk),
		.resetn (resetn),
		.din    (arr_din),
		.addr   (arr_addr),
		.wr     (arr_wr),
		.rd     (arr_rd),
		.clr    (arr_clr),
		.dout   (arr_dout),
		.error  (arr_error)
	);

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic resetn
);

	localparam int half_period = 5;	// 10 ns clock
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release on a falling edge, like all other inputs
	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

// ==== verification/store_checker.sv ====
`timescale 1ns/1ps

module store_checker
	import store_pkg::*;
(
	input logic              clk,
	input logic              resetn,
	input logic [op_w-1:0]   op,
	input logic [addr_w-1:0] addr,
	input logic [data_w-1:0] wdata,
	input logic              ack,
	input logic [data_w-1:0] rdata,
	input logic              err
);

	int check_count = 0;	// responses compared
	int error_count = 0;

	// ******************************
	// reference model
	// ******************************

	logic [data_w-1:0] shadow_mem [data_n];
	logic [data_n-1:0] shadow_valid;

	logic              ack_d;
	logic              resetn_d;
	logic [data_w-1:0] held_rdata;
	logic              held_err;

	// returns {err, rdata} for one command and updates the shadow state
	function automatic logic [data_w:0] ref_response(
		input logic [op_w-1:0]   c_op,
		input logic [addr_w-1:0] c_addr,
		input logic [data_w-1:0] c_wdata
	);
		logic [data_w:0] resp;
		resp = '0;
		case (c_op)
			op_write: begin
				shadow_mem[c_addr]   = c_wdata;
				shadow_valid[c_addr] = 1'b1;
			end
			op_clear: begin
				shadow_valid = '0;
			end
			op_read: begin
				if (shadow_valid[c_addr]) begin
					resp = {1'b0, shadow_mem[c_addr]};
				end else begin
					resp = {1'b1, {data_w{1'b0}}};	// never written
				end
			end
			default: begin
				resp = '0;	// reserved code touches nothing
			end
		endcase
		return resp;
	endfunction

	task automatic report_mismatch(
		input string             name,
		input logic [data_w-1:0] got,
		input logic [data_w-1:0] expected
	);
		$display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
		error_count++;
	endtask

	// ******************************
	// compare
	// ******************************

	// sampled on rising edges, inputs settle at the falling edge before
	always @(posedge clk) begin : watch
		logic [data_w:0] expected;
		if (!resetn) begin
			shadow_valid = '0;
			ack_d      <= 1'b0;
			resetn_d   <= 1'b0;
			held_rdata <= '0;	// response outputs come out of reset low
			held_err   <= 1'b0;
		end else begin
			if (!resetn_d) begin
				if (ack !== 1'b0) report_mismatch("ack", data_w'(ack), '0);
			end
			if (ack && !ack_d) begin
				expected = ref_response(op, addr, wdata);
				check_count++;
				if (rdata !== expected[data_w-1:0]) begin
					report_mismatch("rdata", rdata, expected[data_w-1:0]);
				end
				if (err !== expected[data_w]) begin
					report_mismatch("err", data_w'(err), data_w'(expected[data_w]));
				end
				held_rdata <= rdata;
				held_err   <= err;
			end else begin
				// response must hold until the next command's ack rises
				if (rdata !== held_rdata) report_mismatch("rdata", rdata, held_rdata);
				if (err !== held_err) report_mismatch("err", data_w'(err), data_w'(held_err));
			end
			ack_d    <= ack;
			resetn_d <= 1'b1;
		end
	end

endmodule

// ==== verification/tb_scratch_store.sv ====
`timescale 1ns/1ps

module tb_scratch_store
	import store_pkg::*;
();

	localparam logic [15:0] lfsr_seed = 16'd19;
	localparam int ack_timeout   = 40;	// falling edges
	localparam int drop_timeout  = 40;
	localparam int reset_timeout = 50;
	localparam int rand_cmds     = 200;

	logic              clk;
	logic              resetn;
	logic              req;
	logic [op_w-1:0]   op;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic              ack;
	logic [data_w-1:0] rdata;
	logic              err;

	logic [15:0] lfsr_q;
	int          cmd_count = 0;
	int          local_errors = 0;	// timeouts and lost responses
	int          tests_run = 0;
	int          tests_failed = 0;
	string       test_name;
	int          base_checks;
	int          base_errors;
	int          base_cmds;

	tb_clock u_clock (
		.clk    (clk),
		.resetn (resetn)
	);

	scratch_store dut (
		.clk    (clk),
		.resetn (resetn),
		.req    (req),
		.op     (op),
		.addr   (addr),
		.wdata  (wdata),
		.ack    (ack),
		.rdata  (rdata),
		.err    (err)
	);

	store_checker chk (
		.clk    (clk),
		.resetn (resetn),
		.op     (op),
		.addr   (addr),
		.wdata  (wdata),
		.ack    (ack),
		.rdata  (rdata),
		.err    (err)
	);

	// ******************************
	// random source
	// ******************************

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			val    = {val[14:0], lfsr_q[0]};
		end
	endtask

	// ******************************
	// host transactions
	// ******************************

	task automatic run_cmd(
		input logic [op_w-1:0]   c_op,
		input logic [addr_w-1:0] c_addr,
		input logic [data_w-1:0] c_wdata,
		input int                idle_edges
	);
		int waited;
		@(negedge clk);
		op    = c_op;
		addr  = c_addr;
		wdata = c_wdata;
		req   = 1'b1;
		waited = 0;
		while (!ack && waited < ack_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (!ack) begin
			$display("timeout at %0t: no ack for op %0d addr %0d", $time, c_op, c_addr);
			local_errors++;
		end
		repeat (idle_edges) @(negedge clk);
		req = 1'b0;
		waited = 0;
		while (ack && waited < drop_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (ack) begin
			$display("timeout at %0t: ack stayed high after req dropped", $time);
			local_errors++;
		end
		cmd_count++;
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		base_checks = chk.check_count;
		base_errors = chk.error_count + local_errors;
		base_cmds   = cmd_count;
	endtask

	task automatic end_test();
		int responses;
		int errors;
		responses = chk.check_count - base_checks;
		if (responses != cmd_count - base_cmds) begin
			$display("test %s: checker saw %0d responses for %0d commands",
				test_name, responses, cmd_count - base_cmds);
			local_errors++;
		end
		errors = chk.error_count + local_errors - base_errors;
		tests_run++;
		if (errors != 0) tests_failed++;
		$display("test %0d %s: %0d responses, %0d errors", tests_run, test_name, responses, errors);
	endtask

	// ******************************
	// test sequence
	// ******************************

	initial begin
		int              waited;
		logic [15:0]     bits;
		logic [op_w-1:0] r_op;
		int              total_errors;

		req    = 1'b0;
		op     = '0;
		addr   = '0;
		wdata  = '0;
		lfsr_q = lfsr_seed;

		// resetn may still be unknown at time zero
		waited = 0;
		while (resetn !== 1'b1 && waited < reset_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (resetn !== 1'b1) begin
			$display("reset was never released");
			local_errors++;
		end

		start_test("reset_reads");
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		end_test();

		start_test("write_readback");
		for (int a = 0; a < data_n; a++) run_cmd(op_write, addr_w'(a), data_w'(8'h30 + 7 * a), 0);
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		end_test();

		start_test("overwrite_one");
		run_cmd(op_write, addr_w'(5), 8'hc3, 0);
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		end_test();

		start_test("clear_then_write");
		run_cmd(op_clear, '0, '0, 0);
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		run_cmd(op_write, addr_w'(2), 8'h9e, 0);
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		end_test();

		start_test("reserved_op");
		run_cmd(op_w'(3), addr_w'(2), 8'h55, 0);
		for (int a = 0; a < data_n; a++) run_cmd(op_read, addr_w'(a), '0, 0);
		end_test();

		start_test("random_cmds");
		for (int n = 0; n < rand_cmds; n++) begin
			draw_bits(op_w, bits);
			r_op = op_w'(bits);
			if (r_op == op_clear) begin
				draw_bits(2, bits);
				if (bits[1:0] != 2'b11) r_op = op_write;	// keep clears rare
			end
			draw_bits(addr_w, bits);
			addr = addr_w'(bits);
			draw_bits(data_w, bits);
			wdata = data_w'(bits);
			draw_bits(2, bits);
			run_cmd(r_op, addr, wdata, int'(bits[1:0]));
		end
		end_test();

		total_errors = chk.error_count + local_errors;
		$display("summary: %0d tests, %0d failed, %0d responses checked, %0d errors",
			tests_run, tests_failed, chk.check_count, total_errors);
		if (total_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hw/store_pkg.sv
hw/reg_array.sv
hw/cmd_port.sv
hw/scratch_store.sv
verification/tb_clock.sv
verification/store_checker.sv
verification/tb_scratch_store.sv

// ==== Makefile ====
# Verilator build and run for the scratchpad register store

VERILATOR ?= verilator
TOP       ?= tb_scratch_store
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG)"
	@echo "  VFLAGS=$(VFLAGS) SIM_ARGS=$(SIM_ARGS)"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^TESTBENCH PASSED$$" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
